//--- hw/muldiv_pkg.sv
// shared widths, iteration count and function codes for the multiply/divide unit
// imported by every RTL block and by the testbench reference model

`default_nettype none

package muldiv_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------

  // operand width
  localparam int xlen = 32;

  // full result width, product or packed quotient/remainder
  localparam int result_w = 2 * xlen;

  // one iteration per operand bit
  localparam int iterations = xlen;

  // counter runs iterations-1 down to 0
  localparam int cnt_w = $clog2(iterations);

  // --------------------------------------------------------------------------
  // function codes
  // --------------------------------------------------------------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,  // signed multiply, full 64-bit product
    fn_div  = 2'd1,  // signed divide
    fn_divu = 2'd2   // unsigned divide
  } muldiv_fn_t;

  // --------------------------------------------------------------------------
  // divide result layout
  // --------------------------------------------------------------------------

  // quotient sits in the low half
  localparam int quot_lsb = 0;
  // remainder sits in the high half
  localparam int rem_lsb = xlen;

endpackage

`default_nettype wire

//--- hw/muldiv_resp_if.sv
// response channel from one arithmetic unit to the shared response arbiter
// val/rdy handshake, payload held stable while val is high

`timescale 1ns/1ps
`default_nettype none

interface muldiv_resp_if;
  import muldiv_pkg::*;

  // unit has a finished result
  logic val;
  // arbiter takes it this cycle
  logic rdy;
  // function code of the finished operation
  muldiv_fn_t fn;
  // product, or packed quotient/remainder
  logic [result_w-1:0] result;

  // unit side drives the payload
  modport unit (
    output val,
    output fn,
    output result,
    input  rdy
  );

  // arbiter side, rdy may follow val combinationally
  modport arb (
    input  val,
    input  fn,
    input  result,
    output rdy
  );

endinterface

`default_nettype wire

//--- hw/int_mul_iterative.sv
// iterative shift-and-add signed multiplier, one bit of the multiplier per cycle
// takes fn_mul requests and returns the full signed 64-bit product

`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_val,
  input  muldiv_pkg::muldiv_fn_t      req_fn,
  input  logic [muldiv_pkg::xlen-1:0] req_a,
  input  logic [muldiv_pkg::xlen-1:0] req_b,
  output logic                        rdy,
  muldiv_resp_if.unit                 resp
);
  import muldiv_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  // --------------------------------------------------------------------------
  // control state
  // --------------------------------------------------------------------------

  state_t           state;
  logic [cnt_w-1:0] cnt_reg;

  // --------------------------------------------------------------------------
  // datapath registers
  // --------------------------------------------------------------------------

  // multiplicand magnitude, moves left one bit per iteration
  logic [result_w-1:0] a_reg;
  // multiplier magnitude, moves right one bit per iteration
  logic [xlen-1:0]     b_reg;
  // running sum of partial products
  logic [result_w-1:0] acc_reg;
  logic                sign_a_reg;
  logic                sign_b_reg;

  logic                req_go;
  logic                resp_go;
  logic [xlen-1:0]     mag_a;
  logic [xlen-1:0]     mag_b;
  logic [result_w-1:0] acc_next;
  logic                neg_result;

  // only accept our own function while idle
  assign rdy     = (state == st_idle) && (req_fn == fn_mul);
  assign req_go  = req_val && rdy;
  assign resp_go = resp.val && resp.rdy;

  // two's complement magnitudes, 0x80000000 maps to 2^31 as unsigned
  assign mag_a = req_a[xlen-1] ? (~req_a + 1'b1) : req_a;
  assign mag_b = req_b[xlen-1] ? (~req_b + 1'b1) : req_b;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = b_reg[0] ? (acc_reg + a_reg) : acc_reg;

  // product is negative when exactly one operand was
  assign neg_result = sign_a_reg ^ sign_b_reg;

  // state machine, iteration count runs iterations-1 down to zero
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      cnt_reg <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state   <= st_calc;
            cnt_reg <= cnt_w'(iterations - 1);
          end
        end
        st_calc: begin
          // last iteration happens on the edge that leaves calc
          if (cnt_reg == '0) begin
            state <= st_done;
          end else begin
            cnt_reg <= cnt_reg - 1'b1;
          end
        end
        st_done: begin
          // hold the result until the arbiter takes it
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // datapath, load on acceptance then one shift-and-add step per calc cycle
  always_ff @(posedge clk) begin
    if (req_go) begin
      sign_a_reg <= req_a[xlen-1];
      sign_b_reg <= req_b[xlen-1];
      a_reg      <= result_w'(mag_a);
      b_reg      <= mag_b;
      acc_reg    <= '0;
    end else if (state == st_calc) begin
      acc_reg <= acc_next;
      a_reg   <= a_reg << 1;
      b_reg   <= b_reg >> 1;
    end
  end

  // response, accumulator is frozen while in done
  assign resp.val    = (state == st_done);
  assign resp.fn     = fn_mul;
  assign resp.result = neg_result ? (~acc_reg + 1'b1) : acc_reg;

endmodule

`default_nettype wire

//--- hw/int_div_iterative.sv
// iterative restoring divider for signed and unsigned 32-bit divide
// result packs quotient and remainder, remainder takes the dividend's sign

`timescale 1ns/1ps
`default_nettype none

module int_div_iterative (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_val,
  input  muldiv_pkg::muldiv_fn_t      req_fn,
  input  logic [muldiv_pkg::xlen-1:0] req_a,
  input  logic [muldiv_pkg::xlen-1:0] req_b,
  output logic                        rdy,
  muldiv_resp_if.unit                 resp
);
  import muldiv_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  // --------------------------------------------------------------------------
  // control state
  // --------------------------------------------------------------------------

  state_t           state;
  logic [cnt_w-1:0] cnt_reg;

  // --------------------------------------------------------------------------
  // datapath registers
  // --------------------------------------------------------------------------

  // partial remainder in the upper half, dividend bits then quotient bits below
  logic [result_w-1:0] rq_reg;
  logic [xlen-1:0]     divisor_reg;
  logic                is_signed_reg;
  logic                sign_a_reg;
  logic                sign_b_reg;
  logic                div_zero_reg;

  logic                req_go;
  logic                resp_go;
  logic                req_signed;
  logic                neg_a;
  logic                neg_b;
  logic [xlen-1:0]     mag_a;
  logic [xlen-1:0]     mag_b;

  // one extra bit on the trial subtraction catches a negative result
  logic [xlen:0]       rem_shift;
  logic [xlen:0]       diff;
  logic                sub_ok;
  logic [result_w-1:0] rq_next;

  logic [xlen-1:0]     quot_mag;
  logic [xlen-1:0]     rem_mag;
  logic                quot_neg;
  logic [xlen-1:0]     quot;
  logic [xlen-1:0]     rem;
  logic [result_w-1:0] packed_result;

  // answers both divide flavours
  assign rdy     = (state == st_idle) && ((req_fn == fn_div) || (req_fn == fn_divu));
  assign req_go  = req_val && rdy;
  assign resp_go = resp.val && resp.rdy;

  // unsigned divide never sees a sign
  assign req_signed = (req_fn == fn_div);
  assign neg_a      = req_signed && req_a[xlen-1];
  assign neg_b      = req_signed && req_b[xlen-1];
  assign mag_a      = neg_a ? (~req_a + 1'b1) : req_a;
  assign mag_b      = neg_b ? (~req_b + 1'b1) : req_b;

  // shift left by one and try the subtraction on the top part
  assign rem_shift = rq_reg[result_w-1:xlen-1];
  assign diff      = rem_shift - {1'b0, divisor_reg};
  assign sub_ok    = ~diff[xlen];
  // keep the difference and set a quotient bit, or just shift
  assign rq_next   = sub_ok ? {diff[xlen-1:0], rq_reg[xlen-2:0], 1'b1}
                            : {rq_reg[result_w-2:0], 1'b0};

  // state machine, same cadence as the multiplier
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      cnt_reg <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state   <= st_calc;
            cnt_reg <= cnt_w'(iterations - 1);
          end
        end
        st_calc: begin
          if (cnt_reg == '0) begin
            state <= st_done;
          end else begin
            cnt_reg <= cnt_reg - 1'b1;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // datapath, load magnitudes then one restoring step per calc cycle
  always_ff @(posedge clk) begin
    if (req_go) begin
      is_signed_reg <= req_signed;
      sign_a_reg    <= neg_a;
      sign_b_reg    <= neg_b;
      div_zero_reg  <= (req_b == '0);
      divisor_reg   <= mag_b;
      rq_reg        <= result_w'(mag_a);
    end else if (state == st_calc) begin
      rq_reg <= rq_next;
    end
  end

  // --------------------------------------------------------------------------
  // sign fix-up and packing
  // --------------------------------------------------------------------------

  assign quot_mag = rq_reg[xlen-1:0];
  assign rem_mag  = rq_reg[result_w-1:xlen];

  // divide by zero keeps the all-ones quotient as is
  assign quot_neg = (sign_a_reg ^ sign_b_reg) && !div_zero_reg;
  assign quot     = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  // remainder follows the dividend
  assign rem      = sign_a_reg ? (~rem_mag + 1'b1) : rem_mag;

  always_comb begin
    packed_result = '0;
    packed_result[quot_lsb +: xlen] = quot;
    packed_result[rem_lsb +: xlen]  = rem;
  end

  assign resp.val    = (state == st_done);
  assign resp.fn     = is_signed_reg ? fn_div : fn_divu;
  assign resp.result = packed_result;

endmodule

`default_nettype wire

//--- hw/resp_arbiter.sv
// round-robin merge of the multiplier and divider response channels
// grant is combinational, the chosen channel passes straight to the port

`timescale 1ns/1ps
`default_nettype none

module resp_arbiter (
  input  logic                            clk,
  input  logic                            reset,
  muldiv_resp_if.arb                      mul_ch,
  muldiv_resp_if.arb                      div_ch,
  output logic                            resp_val,
  input  logic                            resp_rdy,
  output muldiv_pkg::muldiv_fn_t          resp_fn,
  output logic [muldiv_pkg::result_w-1:0] resp_result
);

  // set when the divider won the last transfer
  logic last_grant_div;
  logic grant_div;
  logic grant_mul;
  logic resp_go;

  // --------------------------------------------------------------------------
  // grant
  // --------------------------------------------------------------------------

  // divider wins alone, or on a tie when the multiplier went last
  assign grant_div = div_ch.val && (!mul_ch.val || !last_grant_div);
  assign grant_mul = mul_ch.val && !grant_div;

  // --------------------------------------------------------------------------
  // output mux
  // --------------------------------------------------------------------------

  assign resp_val    = mul_ch.val || div_ch.val;
  assign resp_fn     = grant_div ? div_ch.fn : mul_ch.fn;
  assign resp_result = grant_div ? div_ch.result : mul_ch.result;
  assign resp_go     = resp_val && resp_rdy;

  // only the granted channel sees the port's ready
  assign mul_ch.rdy = resp_rdy && grant_mul;
  assign div_ch.rdy = resp_rdy && grant_div;

  // remember the winner of each transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant_div <= 1'b0;
    end else if (resp_go) begin
      last_grant_div <= grant_div;
    end
  end

endmodule

`default_nettype wire

//--- hw/muldiv_unit.sv
// top of the multiply/divide unit, one shared request port and one response port
// requests go to both units, each unit claims only its own function codes

`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
  input  logic                            clk,
  input  logic                            reset,

  // request port
  input  logic                            req_val,
  input  muldiv_pkg::muldiv_fn_t          req_fn,
  input  logic [muldiv_pkg::xlen-1:0]     req_a,
  input  logic [muldiv_pkg::xlen-1:0]     req_b,
  output logic                            req_rdy,

  // response port
  output logic                            resp_val,
  input  logic                            resp_rdy,
  output muldiv_pkg::muldiv_fn_t          resp_fn,
  output logic [muldiv_pkg::result_w-1:0] resp_result
);

  logic mul_rdy;
  logic div_rdy;

  // one response channel per unit
  muldiv_resp_if mul_resp_ch ();
  muldiv_resp_if div_resp_ch ();

  // --------------------------------------------------------------------------
  // arithmetic units
  // --------------------------------------------------------------------------

  int_mul_iterative mul_inst (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_fn  (req_fn),
    .req_a   (req_a),
    .req_b   (req_b),
    .rdy     (mul_rdy),
    .resp    (mul_resp_ch.unit)
  );

  int_div_iterative div_inst (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_fn  (req_fn),
    .req_a   (req_a),
    .req_b   (req_b),
    .rdy     (div_rdy),
    .resp    (div_resp_ch.unit)
  );

  // the units never claim the same code, so an OR is enough
  assign req_rdy = mul_rdy || div_rdy;

  // --------------------------------------------------------------------------
  // response merge
  // --------------------------------------------------------------------------

  resp_arbiter arb_inst (
    .clk         (clk),
    .reset       (reset),
    .mul_ch      (mul_resp_ch.arb),
    .div_ch      (div_resp_ch.arb),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

//--- verification/muldiv_model.svh
// reference model for the multiply/divide testbench
// included inside the testbench module after the package import

`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// expected results per unit, oldest request at the front
logic [result_w-1:0] mul_expect_q[$];
logic [result_w-1:0] div_expect_q[$];
// the divider also returns the function code it was given
muldiv_fn_t          div_fn_q[$];

// full signed product, both operands sign-extended to 64 bits first
function automatic logic [result_w-1:0] model_mul(input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
  logic signed [result_w-1:0] sa;
  logic signed [result_w-1:0] sb;
  sa = {{xlen{a[xlen-1]}}, a};
  sb = {{xlen{b[xlen-1]}}, b};
  return sa * sb;
endfunction

// quotient and remainder packed at quot_lsb and rem_lsb
function automatic logic [result_w-1:0] model_div(input muldiv_fn_t      fn,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
  logic signed [result_w-1:0] sa;
  logic signed [result_w-1:0] sb;
  logic [xlen-1:0]            q;
  logic [xlen-1:0]            r;
  logic [result_w-1:0]        res;
  if (b == '0) begin
    // divide by zero, all-ones quotient and the dividend back
    q = '1;
    r = a;
  end else if (fn == fn_div) begin
    // 64-bit signed math, so most-negative / -1 wraps to 0x80000000
    sa = {{xlen{a[xlen-1]}}, a};
    sb = {{xlen{b[xlen-1]}}, b};
    q  = xlen'(sa / sb);
    r  = xlen'(sa % sb);
  end else begin
    q = a / b;
    r = a % b;
  end
  res = '0;
  res[quot_lsb +: xlen] = q;
  res[rem_lsb +: xlen]  = r;
  return res;
endfunction

// queue the expected response for whichever unit takes this code
task automatic push_expected(input muldiv_fn_t      fn,
                             input logic [xlen-1:0] a,
                             input logic [xlen-1:0] b);
  if (fn == fn_mul) begin
    mul_expect_q.push_back(model_mul(a, b));
  end else begin
    div_expect_q.push_back(model_div(fn, a, b));
    div_fn_q.push_back(fn);
  end
endtask

`endif

//--- verification/muldiv_tb.sv
// random and corner-case testbench for the multiply/divide unit
// checks every response against the reference model, per unit and in order

`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;
  import muldiv_pkg::*;

  `include "muldiv_model.svh"

  localparam int clk_period         = 100;
  localparam int reset_cycles       = 8;
  localparam int num_requests       = 400;
  localparam int num_directed       = 8;
  localparam int cycles_per_request = 80;
  localparam int watchdog_cycles    = num_requests * cycles_per_request + reset_cycles;

  // fixed opening requests so the rare corners are always hit
  localparam muldiv_fn_t directed_fn [num_directed] = '{
    fn_mul, fn_mul, fn_div, fn_div, fn_div, fn_divu, fn_divu, fn_divu
  };
  localparam logic [xlen-1:0] directed_a [num_directed] = '{
    32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 32'hffff_fff9,
    32'h0000_0007, 32'hffff_ffff, 32'h8000_0000, 32'hffff_fff0
  };
  localparam logic [xlen-1:0] directed_b [num_directed] = '{
    32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0002,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0003, 32'h0000_0010
  };

  logic                clk;
  logic                reset;
  logic                req_val;
  muldiv_fn_t          req_fn;
  logic [xlen-1:0]     req_a;
  logic [xlen-1:0]     req_b;
  logic                req_rdy;
  logic                resp_val;
  logic                resp_rdy;
  muldiv_fn_t          resp_fn;
  logic [result_w-1:0] resp_result;

  integer seed;
  // goes high on the first accepted request
  bit     seen_accept;

  muldiv_unit muldiv_unit_inst (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // one clock with fresh random back-pressure on the response port
  task automatic next_cycle();
    int unsigned pick;
    @(posedge clk);
    pick = $unsigned($random(seed));
    resp_rdy <= (pick % 4 != 0);
  endtask

  // roughly one operand in four is a corner value
  function automatic logic [xlen-1:0] random_operand();
    int unsigned pick;
    pick = $unsigned($random(seed));
    if (pick % 4 != 0) begin
      return $random(seed);
    end
    pick = $unsigned($random(seed));
    case (pick % 5)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      default: return 32'h7fff_ffff;
    endcase
  endfunction

  task automatic random_case(output muldiv_fn_t fn,
                             output logic [xlen-1:0] a, output logic [xlen-1:0] b);
    int unsigned pick;
    pick = $unsigned($random(seed));
    case (pick % 3)
      0:       fn = fn_mul;
      1:       fn = fn_div;
      default: fn = fn_divu;
    endcase
    a = random_operand();
    b = random_operand();
  endtask

  // pops the front entry of the unit named by resp_fn and compares
  task automatic check_response();
    logic [result_w-1:0] expect_result;
    muldiv_fn_t          expect_fn;
    if (resp_fn == fn_mul) begin
      assert (mul_expect_q.size() > 0) else
        stop_on_error("a multiply response arrived with no multiply pending");
      expect_result = mul_expect_q.pop_front();
      assert (resp_result == expect_result) else
        stop_on_error($sformatf("ERROR: resp_result (mul) got %h expected %h",
                                resp_result, expect_result));
    end else begin
      assert (resp_fn == fn_div || resp_fn == fn_divu) else
        stop_on_error($sformatf("ERROR: resp_fn got %h, not a valid code", resp_fn));
      assert (div_expect_q.size() > 0) else
        stop_on_error("a divide response arrived with no divide pending");
      expect_result = div_expect_q.pop_front();
      expect_fn     = div_fn_q.pop_front();
      assert (resp_fn == expect_fn) else
        stop_on_error($sformatf("ERROR: resp_fn got %h expected %h", resp_fn, expect_fn));
      assert (resp_result == expect_result) else
        stop_on_error($sformatf("ERROR: resp_result (div) got %h expected %h",
                                resp_result, expect_result));
    end
  endtask

  // --------------------------------------------------------------------------
  // response checker samples on the edge where the transfer happens
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      assert (seen_accept || !resp_val) else
        stop_on_error("resp_val went high before any request was accepted");
      if (resp_val && resp_rdy) begin
        check_response();
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  initial begin : stimulus
    muldiv_fn_t      fn;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    seed        = 21786;
    seen_accept <= 1'b0;
    reset    <= 1'b1;
    req_val  <= 1'b0;
    req_fn   <= fn_mul;
    req_a    <= '0;
    req_b    <= '0;
    resp_rdy <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    for (int n = 0; n < num_requests; n++) begin
      if (n < num_directed) begin
        fn = directed_fn[n];
        a  = directed_a[n];
        b  = directed_b[n];
      end else begin
        random_case(fn, a, b);
      end
      req_val <= 1'b1;
      req_fn  <= fn;
      req_a   <= a;
      req_b   <= b;
      // hold the request until the owning unit takes it
      do begin
        next_cycle();
      end while (!req_rdy);
      push_expected(fn, a, b);
      seen_accept <= 1'b1;
    end
    req_val <= 1'b0;

    // drain both units then leave time for any stray response
    while (mul_expect_q.size() != 0 || div_expect_q.size() != 0) begin
      next_cycle();
    end
    repeat (2 * iterations) next_cycle();

    $display("Done: no errors");
    $finish;
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    stop_on_error("watchdog expired with responses still outstanding");
  end

endmodule

`default_nettype wire

//--- muldiv.f
hw/muldiv_pkg.sv
hw/muldiv_resp_if.sv
hw/int_mul_iterative.sv
hw/int_div_iterative.sv
hw/resp_arbiter.sv
hw/muldiv_unit.sv
+incdir+verification
verification/muldiv_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the multiply/divide testbench with Verilator and runs it
# the run counts as passed only when the pass line shows up in the output

set -e

cd "$(dirname "$0")"

# immediate assertions in the testbench need --assert
verilator --binary --timing --assert \
  --top-module muldiv_tb \
  -f muldiv.f

# a fatal stop must not skip the output check below
output=$(./obj_dir/Vmuldiv_tb || true)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
